// File: src/msx_glue_pkg.sv
/* MSX board glue package
   SD-card SPI types, HDMI crop table constants and aspect option codes */

package msx_glue_pkg;

   // ======================================================================
   // SPI byte engine
   // ======================================================================

   typedef logic [7:0] spi_byte_t;

   localparam int SPI_BITS = 8;

   // Five-bit counter, top bit set means idle
   localparam int SPI_COUNT_W = 5;

   // Shifted out on a read strobe
   localparam spi_byte_t SPI_FILL_BYTE = 8'hFF;

   // About 47 ms at 21.48 MHz
   localparam int ACT_HOLD_CYCLES = 1000000;

   // ======================================================================
   // HDMI crop and aspect
   // ======================================================================

   typedef logic [11:0] hdmi_dim_t;
   typedef logic [9:0]  crop_t;
   typedef logic [11:0] aspect_t;

   // Aspect ratio option from the user menu
   typedef enum logic [1:0] {
      AR_ORIGINAL = 2'd0,
      AR_FULL     = 2'd1,
      AR_CUSTOM1  = 2'd2,
      AR_CUSTOM2  = 2'd3
   } aspect_mode_e;

   localparam aspect_t ARX_NORMAL = 12'd400;
   localparam aspect_t ARX_WIDE   = 12'd340;
   localparam aspect_t ARY_NORMAL = 12'd300;

   // 4:3 modes taller than the width/height ratio rule allows
   localparam hdmi_dim_t WIDE43_MIN_WIDTH = 12'd1440;

   // Output heights found in the crop table
   localparam hdmi_dim_t H_480  = 12'd480;
   localparam hdmi_dim_t H_600  = 12'd600;
   localparam hdmi_dim_t H_720  = 12'd720;
   localparam hdmi_dim_t H_768  = 12'd768;
   localparam hdmi_dim_t H_800  = 12'd800;
   localparam hdmi_dim_t H_1080 = 12'd1080;
   localparam hdmi_dim_t H_1200 = 12'd1200;
   localparam hdmi_dim_t H_1440 = 12'd1440;
   localparam hdmi_dim_t H_1536 = 12'd1536;

   // Crop heights picked by the table
   localparam crop_t CROP_240 = 10'd240;
   localparam crop_t CROP_200 = 10'd200;
   localparam crop_t CROP_256 = 10'd256;
   localparam crop_t CROP_216 = 10'd216;

endpackage

// File: src/spi_byte_engine.sv
/* SPI byte engine
   Shifts one byte MSB first per transfer, two system clocks per bit */

`timescale 1ns/1ps

module spi_byte_engine (
   input  logic                    clk21m,
   input  logic                    reset,
   input  logic                    tx,
   input  logic                    rx,
   input  msx_glue_pkg::spi_byte_t tx_data,
   input  logic                    spi_miso,
   output logic                    ready,
   output msx_glue_pkg::spi_byte_t rx_data,
   output logic                    spi_sck,
   output logic                    spi_mosi
);

   import msx_glue_pkg::*;

   // Transfer counter, bit 0 is the serial clock and the top bit is idle
   logic [SPI_COUNT_W-1:0] counter;

   // Outgoing bits leave at the top, incoming bits enter at the bottom
   spi_byte_t io_byte;

   // Byte from the previous transfer
   spi_byte_t data_q;

   logic start;

   assign ready    = counter[SPI_COUNT_W-1];
   assign spi_sck  = counter[0];
   assign spi_mosi = io_byte[SPI_BITS-1];
   assign rx_data  = data_q;

   // Strobes are only taken while idle
   assign start = ready & (tx | rx);

   // ======================================================================
   // Counter and shifter
   // ======================================================================

   always_ff @(posedge clk21m) begin
      if (reset) begin
         counter <= {1'b1, {(SPI_COUNT_W-1){1'b0}}};
         io_byte <= SPI_FILL_BYTE;
         data_q  <= '0;
      end else if (ready) begin
         if (start) begin
            counter <= '0;
            // Capture what the card sent during the last transfer
            data_q  <= io_byte;
            io_byte <= tx ? tx_data : SPI_FILL_BYTE;
         end
      end else begin
         // End of a high phase: sample MISO, present next MOSI bit
         if (spi_sck) begin
            io_byte <= {io_byte[SPI_BITS-2:0], spi_miso};
         end
         counter <= counter + SPI_COUNT_W'(1);
      end
   end

endmodule

// File: src/sd_activity_monitor.sv
/* SD activity monitor
   Holds active high for a while after any MOSI or MISO toggle */

`timescale 1ns/1ps

module sd_activity_monitor #(
   parameter int hold_cycles = msx_glue_pkg::ACT_HOLD_CYCLES
) (
   input  logic clk21m,
   input  logic reset,
   input  logic spi_mosi,
   input  logic spi_miso,
   output logic active
);

   import msx_glue_pkg::*;

   localparam int CNT_W = $clog2(hold_cycles + 1);
   localparam logic [CNT_W-1:0] HOLD_MAX = CNT_W'(hold_cycles);

   logic             old_mosi;
   logic             old_miso;
   logic [CNT_W-1:0] hold_cnt;
   logic             toggle;

   assign toggle = (old_mosi ^ spi_mosi) | (old_miso ^ spi_miso);

   // Previous line levels
   always_ff @(posedge clk21m) begin
      old_mosi <= spi_mosi;
      old_miso <= spi_miso;
   end

   // Saturating hold counter, restarts on every toggle
   always_ff @(posedge clk21m) begin
      if (reset) begin
         hold_cnt <= HOLD_MAX;
         active   <= 1'b0;
      end else begin
         if (toggle) begin
            hold_cnt <= '0;
         end else if (hold_cnt < HOLD_MAX) begin
            hold_cnt <= hold_cnt + CNT_W'(1);
         end
         active <= (hold_cnt < HOLD_MAX);
      end
   end

endmodule

// File: src/sd_route.sv
/* SD line router
   Selects virtual or physical card, gates its SPI lines and drives LEDs */

`timescale 1ns/1ps

module sd_route #(
   parameter int hold_cycles = msx_glue_pkg::ACT_HOLD_CYCLES
) (
   input  logic        clk21m,
   input  logic        reset,
   input  logic        img_mounted,
   input  logic [31:0] img_size,
   input  logic        card_ss,
   input  logic        spi_sck,
   input  logic        spi_mosi,
   input  logic        sd_miso,
   input  logic        vsd_miso,
   output logic        spi_miso,
   output logic        sd_cs,
   output logic        sd_sck,
   output logic        sd_mosi,
   output logic        vsd_cs,
   output logic        vsd_sck,
   output logic        vsd_mosi,
   output logic        led_user,
   output logic        led_disk
);

   import msx_glue_pkg::*;

   // High while the image-backed card is in use
   logic vsd_sel;
   logic active;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         vsd_sel <= 1'b0;
      end else if (img_mounted) begin
         vsd_sel <= |img_size;
      end
   end

   // Physical card is held deselected and quiet while virtual is active
   assign sd_cs    = card_ss | vsd_sel;
   assign sd_sck   = spi_sck & ~vsd_sel;
   assign sd_mosi  = spi_mosi & ~vsd_sel;

   assign vsd_cs   = card_ss | ~vsd_sel;
   assign vsd_sck  = spi_sck;
   assign vsd_mosi = spi_mosi;

   assign spi_miso = vsd_sel ? vsd_miso : sd_miso;

   sd_activity_monitor #(
      .hold_cycles (hold_cycles)
   ) u_activity (
      .clk21m   (clk21m),
      .reset    (reset),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso),
      .active   (active)
   );

   assign led_user = active & vsd_sel;
   assign led_disk = active & ~vsd_sel;

endmodule

// File: src/hdmi_crop_select.sv
/* HDMI crop and aspect selector
   Picks vertical crop, wide flag and aspect numbers from the HDMI mode */

`timescale 1ns/1ps

module hdmi_crop_select (
   input  logic                       clk21m,
   input  logic                       reset,
   input  msx_glue_pkg::hdmi_dim_t    hdmi_width,
   input  msx_glue_pkg::hdmi_dim_t    hdmi_height,
   input  logic                       forced_scandoubler,
   input  logic [1:0]                 scanlines,
   input  logic                       vcrop_en,
   input  msx_glue_pkg::aspect_mode_e ar,
   output msx_glue_pkg::crop_t        crop_size,
   output msx_glue_pkg::aspect_t      arx,
   output msx_glue_pkg::aspect_t      ary
);

   import msx_glue_pkg::*;

   logic         scandoubler;
   logic [12:0]  ratio_limit;
   crop_t        vcrop_d;
   logic         wide_d;

   crop_t        vcrop_q;
   logic         wide_q;
   logic         vcrop_en_q;
   aspect_mode_e ar_q;

   assign scandoubler = forced_scandoubler | (|scanlines);

   // Height plus half height, kept one bit wider to avoid wrap
   assign ratio_limit = {1'b0, hdmi_height} + 13'(hdmi_height[11:1]);

   // ======================================================================
   // Crop table
   // ======================================================================

   always_comb begin
      vcrop_d = '0;
      wide_d  = 1'b0;
      if (!scandoubler && ({1'b0, hdmi_width} >= ratio_limit)) begin
         case (hdmi_height)
            H_480, H_720, H_1200: vcrop_d = CROP_240;
            H_600, H_800: begin
               vcrop_d = CROP_200;
               wide_d  = vcrop_en;
            end
            // NTSC only shows about 250 lines here
            H_768:  vcrop_d = CROP_256;
            H_1080: vcrop_d = CROP_216;
            default: vcrop_d = '0;
         endcase
      end else if (!scandoubler && (hdmi_width >= WIDE43_MIN_WIDTH)) begin
         // Tall 4:3 modes
         case (hdmi_height)
            H_1440:  vcrop_d = CROP_240;
            H_1536:  vcrop_d = CROP_256;
            default: vcrop_d = '0;
         endcase
      end
   end

   // Stage 1, options ride along so every input sees the same latency
   always_ff @(posedge clk21m) begin
      if (reset) begin
         vcrop_q    <= '0;
         wide_q     <= 1'b0;
         vcrop_en_q <= 1'b0;
         ar_q       <= AR_ORIGINAL;
      end else begin
         vcrop_q    <= vcrop_d;
         wide_q     <= wide_d;
         vcrop_en_q <= vcrop_en;
         ar_q       <= ar;
      end
   end

   // ======================================================================
   // Output stage
   // ======================================================================

   always_ff @(posedge clk21m) begin
      if (reset) begin
         crop_size <= '0;
         arx       <= '0;
         ary       <= '0;
      end else begin
         crop_size <= vcrop_en_q ? vcrop_q : crop_t'(0);
         if (ar_q == AR_ORIGINAL) begin
            arx <= wide_q ? ARX_WIDE : ARX_NORMAL;
            ary <= ARY_NORMAL;
         end else begin
            // Scaler takes the option index for non-original modes
            arx <= aspect_t'(ar_q) - aspect_t'(1);
            ary <= '0;
         end
      end
   end

endmodule

// File: src/msx_board_io.sv
/* MSX board I/O glue top
   SD-card SPI engine with card routing, plus HDMI crop and aspect select */

`timescale 1ns/1ps

module msx_board_io #(
   parameter int hold_cycles = msx_glue_pkg::ACT_HOLD_CYCLES
) (
   input  logic                       clk21m,
   input  logic                       reset,

   // SPI byte requests
   input  logic                       tx,
   input  logic                       rx,
   input  msx_glue_pkg::spi_byte_t    tx_data,
   output logic                       ready,
   output msx_glue_pkg::spi_byte_t    rx_data,

   // Card select and image mount
   input  logic                       card_ss,
   input  logic                       img_mounted,
   input  logic [31:0]                img_size,

   // Physical card
   output logic                       sd_cs,
   output logic                       sd_sck,
   output logic                       sd_mosi,
   input  logic                       sd_miso,

   // Virtual card
   output logic                       vsd_cs,
   output logic                       vsd_sck,
   output logic                       vsd_mosi,
   input  logic                       vsd_miso,

   output logic                       led_user,
   output logic                       led_disk,

   // Video options
   input  msx_glue_pkg::hdmi_dim_t    hdmi_width,
   input  msx_glue_pkg::hdmi_dim_t    hdmi_height,
   input  logic                       forced_scandoubler,
   input  logic [1:0]                 scanlines,
   input  logic                       vcrop_en,
   input  msx_glue_pkg::aspect_mode_e ar,
   output msx_glue_pkg::crop_t        crop_size,
   output msx_glue_pkg::aspect_t      arx,
   output msx_glue_pkg::aspect_t      ary
);

   import msx_glue_pkg::*;

   logic spi_sck;
   logic spi_mosi;
   logic spi_miso;

   // ======================================================================
   // SD card path
   // ======================================================================

   spi_byte_engine u_spi (
      .clk21m   (clk21m),
      .reset    (reset),
      .tx       (tx),
      .rx       (rx),
      .tx_data  (tx_data),
      .spi_miso (spi_miso),
      .ready    (ready),
      .rx_data  (rx_data),
      .spi_sck  (spi_sck),
      .spi_mosi (spi_mosi)
   );

   sd_route #(
      .hold_cycles (hold_cycles)
   ) u_route (
      .clk21m      (clk21m),
      .reset       (reset),
      .img_mounted (img_mounted),
      .img_size    (img_size),
      .card_ss     (card_ss),
      .spi_sck     (spi_sck),
      .spi_mosi    (spi_mosi),
      .sd_miso     (sd_miso),
      .vsd_miso    (vsd_miso),
      .spi_miso    (spi_miso),
      .sd_cs       (sd_cs),
      .sd_sck      (sd_sck),
      .sd_mosi     (sd_mosi),
      .vsd_cs      (vsd_cs),
      .vsd_sck     (vsd_sck),
      .vsd_mosi    (vsd_mosi),
      .led_user    (led_user),
      .led_disk    (led_disk)
   );

   // ======================================================================
   // Video crop
   // ======================================================================

   hdmi_crop_select u_crop (
      .clk21m             (clk21m),
      .reset              (reset),
      .hdmi_width         (hdmi_width),
      .hdmi_height        (hdmi_height),
      .forced_scandoubler (forced_scandoubler),
      .scanlines          (scanlines),
      .vcrop_en           (vcrop_en),
      .ar                 (ar),
      .crop_size          (crop_size),
      .arx                (arx),
      .ary                (ary)
   );

endmodule

// File: bench/msx_board_io_assert.sv
/* MSX board I/O assertions
   Chip-select exclusion, SPI busy length and physical-line gating */

`timescale 1ns/1ps

module msx_board_io_assert (
   input logic clk21m,
   input logic reset,
   input logic tx,
   input logic rx,
   input logic ready,
   input logic card_ss,
   input logic sd_cs,
   input logic sd_sck,
   input logic sd_mosi,
   input logic vsd_cs
);

   // Cycles since an accepted strobe, zero when nothing is in flight
   logic [4:0] busy_age;
   int         failures = 0;

   always_ff @(posedge clk21m) begin
      if (reset) begin
         busy_age <= '0;
      end else if (ready && (tx || rx)) begin
         busy_age <= 5'd1;
      end else if ((busy_age != 5'd0) && (busy_age < 5'd17)) begin
         busy_age <= busy_age + 5'd1;
      end else begin
         busy_age <= '0;
      end
   end

   cs_exclusive: assert property (@(posedge clk21m) disable iff (reset)
      sd_cs || vsd_cs)
      else begin
         $error("both chip selects low");
         failures = failures + 1;
      end

   busy_low: assert property (@(posedge clk21m) disable iff (reset)
      ((busy_age >= 5'd1) && (busy_age <= 5'd16)) |-> !ready)
      else begin
         $error("ready high during a transfer");
         failures = failures + 1;
      end

   busy_end: assert property (@(posedge clk21m) disable iff (reset)
      (busy_age == 5'd17) |-> ready)
      else begin
         $error("ready not back 16 cycles after the strobe");
         failures = failures + 1;
      end

   // Physical card stays quiet while the virtual card talks
   phys_gated: assert property (@(posedge clk21m) disable iff (reset)
      (!vsd_cs && !card_ss) |-> (!sd_sck && !sd_mosi))
      else begin
         $error("physical card lines active while virtual card selected");
         failures = failures + 1;
      end

endmodule

bind msx_board_io msx_board_io_assert u_checks (
   .clk21m  (clk21m),
   .reset   (reset),
   .tx      (tx),
   .rx      (rx),
   .ready   (ready),
   .card_ss (card_ss),
   .sd_cs   (sd_cs),
   .sd_sck  (sd_sck),
   .sd_mosi (sd_mosi),
   .vsd_cs  (vsd_cs)
);

// File: bench/tb_msx_board_io.sv
/* MSX board I/O testbench
   SPI transfers on both cards, activity LEDs and the HDMI crop table */

`timescale 1ns/1ps

module tb_msx_board_io;

   import msx_glue_pkg::*;

   logic         clk21m, reset;
   logic         tx, rx, ready;
   spi_byte_t    tx_data, rx_data;
   logic         card_ss, img_mounted;
   logic [31:0]  img_size;
   logic         sd_cs, sd_sck, sd_mosi, sd_miso;
   logic         vsd_cs, vsd_sck, vsd_mosi, vsd_miso;
   logic         led_user, led_disk;
   hdmi_dim_t    hdmi_width, hdmi_height;
   logic         forced_scandoubler, vcrop_en;
   logic [1:0]   scanlines;
   aspect_mode_e ar;
   crop_t        crop_size;
   aspect_t      arx, ary;

   logic [15:0]  lfsr_state;
   logic         virt_sel;
   logic         have_reply;
   spi_byte_t    last_reply;

   msx_board_io #(.hold_cycles(200)) DUT (
      .clk21m (clk21m), .reset (reset), .tx (tx), .rx (rx), .tx_data (tx_data),
      .ready (ready), .rx_data (rx_data), .card_ss (card_ss),
      .img_mounted (img_mounted), .img_size (img_size),
      .sd_cs (sd_cs), .sd_sck (sd_sck), .sd_mosi (sd_mosi), .sd_miso (sd_miso),
      .vsd_cs (vsd_cs), .vsd_sck (vsd_sck), .vsd_mosi (vsd_mosi), .vsd_miso (vsd_miso),
      .led_user (led_user), .led_disk (led_disk),
      .hdmi_width (hdmi_width), .hdmi_height (hdmi_height),
      .forced_scandoubler (forced_scandoubler), .scanlines (scanlines),
      .vcrop_en (vcrop_en), .ar (ar), .crop_size (crop_size), .arx (arx), .ary (ary)
   );

   always #4 clk21m = ~clk21m;

   // ======================================================================
   // Reference models and helpers
   // ======================================================================

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   task automatic next_random(input int nbits, output logic [15:0] value);
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[14:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
   endtask

   // {sd_cs, vsd_cs}
   function automatic logic [1:0] cs_ref(input logic ss, input logic sel);
      return {ss | sel, ss | ~sel};
   endfunction

   // {crop_size, arx, ary}
   function automatic logic [33:0] crop_ref(input int w, input int h, input logic sd_on,
                                            input logic vcrop, input int mode);
      int   vc;
      int   ax;
      int   ay;
      logic wide;
      vc = 0;
      wide = 1'b0;
      if (!sd_on && (w >= h + h / 2)) begin
         if (h == 480 || h == 720 || h == 1200) vc = 240;
         else if (h == 600 || h == 800) begin
            vc = 200;
            wide = vcrop;
         end
         else if (h == 768) vc = 256;
         else if (h == 1080) vc = 216;
      end else if (!sd_on && (w >= 1440)) begin
         if (h == 1440) vc = 240;
         else if (h == 1536) vc = 256;
      end
      if (!vcrop) vc = 0;
      if (mode == 0) begin
         ax = wide ? 340 : 400;
         ay = 300;
      end else begin
         ax = mode - 1;
         ay = 0;
      end
      return {10'(vc), 12'(ax), 12'(ay)};
   endfunction

   task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                              input string what);
      if (actual !== expected) begin
         $display("** Error [%0t] %s: got 0x%0h, expected 0x%0h",
                  $time, what, actual, expected);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout: %s", what);
      $display("Simulation failed");
      $fatal(1, "timeout");
   endtask

   task automatic wait_ready();
      int i;
      for (i = 0; i < 64; i++) begin
         @(negedge clk21m);
         if (ready) break;
      end
      if (i == 64) report_timeout("ready did not return high");
   endtask

   // Selected card sends the bit, the other one its inverse
   task automatic drive_miso(input logic b);
      sd_miso  <= b ^ virt_sel;
      vsd_miso <= b ^ ~virt_sel;
   endtask

   // ======================================================================
   // SPI transfer with card model
   // ======================================================================

   task automatic run_transfer(input logic use_rx, input spi_byte_t data,
                               input spi_byte_t reply);
      spi_byte_t sent, expect_byte, miso_byte;
      int        bits, n, since;
      logic      shift_edge, cur_mosi, cur_miso, prev_mosi, prev_miso;
      expect_byte = use_rx ? 8'hFF : data;
      miso_byte = reply;
      sent = '0;
      bits = 0;
      since = -1;
      wait_ready();
      prev_mosi = vsd_mosi;
      prev_miso = virt_sel ? vsd_miso : sd_miso;
      @(posedge clk21m);
      tx      <= ~use_rx;
      rx      <= use_rx;
      tx_data <= data;
      drive_miso(miso_byte[7]);
      @(posedge clk21m);
      tx <= 1'b0;
      rx <= 1'b0;
      for (n = 0; n <= 40; n++) begin
         @(negedge clk21m);
         if (ready) break;
         if (n == 0 && have_reply)
            check_value(64'(rx_data), 64'(last_reply), "rx_data from previous transfer");
         check_value(64'({sd_cs, vsd_cs}), 64'(cs_ref(card_ss, virt_sel)), "chip selects");
         if (virt_sel) check_value(64'({sd_sck, sd_mosi}), 64'd0, "gated physical lines");
         cur_mosi = vsd_mosi;
         cur_miso = virt_sel ? vsd_miso : sd_miso;
         // Cycles since the first line change of this transfer
         if (since >= 0)
            since++;
         else if ((cur_mosi != prev_mosi) || (cur_miso != prev_miso))
            since = 0;
         prev_mosi = cur_mosi;
         prev_miso = cur_miso;
         if (since >= 3)
            check_value(64'(virt_sel ? led_user : led_disk), 64'd1, "selected card LED");
         check_value(64'(virt_sel ? led_disk : led_user), 64'd0, "other card LED");
         shift_edge = virt_sel ? vsd_sck : sd_sck;
         if (shift_edge) begin
            sent = {sent[6:0], virt_sel ? vsd_mosi : sd_mosi};
            bits++;
         end
         @(posedge clk21m);
         // Card moves to its next bit as the serial clock falls
         if (shift_edge && bits < 8) begin
            miso_byte = {miso_byte[6:0], 1'b0};
            drive_miso(miso_byte[7]);
         end
      end
      if (n > 40) report_timeout("transfer did not finish");
      check_value(64'(n), 64'd16, "cycles with ready low");
      check_value(64'(bits), 64'd8, "serial clock pulses");
      check_value(64'(sent), 64'(expect_byte), "byte on MOSI");
      last_reply = reply;
      have_reply = 1'b1;
   endtask

   task automatic mount_image(input logic [31:0] size);
      @(posedge clk21m);
      img_mounted <= 1'b1;
      img_size    <= size;
      @(posedge clk21m);
      img_mounted <= 1'b0;
      virt_sel = (size != 32'd0);
      @(negedge clk21m);
      check_value(64'({sd_cs, vsd_cs}), 64'(cs_ref(card_ss, virt_sel)), "selects after mount");
   endtask

   task automatic check_card_ss();
      @(posedge clk21m);
      card_ss <= 1'b1;
      @(negedge clk21m);
      check_value(64'({sd_cs, vsd_cs}), 64'(cs_ref(1'b1, virt_sel)), "selects with card_ss");
      @(posedge clk21m);
      card_ss <= 1'b0;
   endtask

   task automatic check_leds_idle();
      repeat (210) @(posedge clk21m);
      @(negedge clk21m);
      check_value(64'({led_user, led_disk}), 64'd0, "LEDs after idle time");
   endtask

   task automatic random_transfers(input int count, input logic mixed);
      logic [15:0] r_data, r_reply, r_pick;
      for (int k = 0; k < count; k++) begin
         r_pick = '0;
         if (mixed) next_random(1, r_pick);
         next_random(8, r_data);
         next_random(8, r_reply);
         run_transfer(r_pick[0], r_data[7:0], r_reply[7:0]);
      end
   endtask

   // ======================================================================
   // Crop and aspect sweep
   // ======================================================================

   task automatic sweep_crop();
      int          heights [11] = '{480, 600, 720, 768, 800, 1080, 1200, 1440, 1536, 500, 1024};
      int          widths [4];
      logic [33:0] expect_out;
      foreach (heights[hi]) begin
         widths[0] = heights[hi] + heights[hi] / 2 - 1;
         widths[1] = heights[hi] + heights[hi] / 2;
         widths[2] = 1439;
         widths[3] = 1440;
         for (int wi = 0; wi < 4; wi++)
            for (int sdm = 0; sdm < 3; sdm++)
               for (int vc = 0; vc < 2; vc++)
                  for (int mode = 0; mode < 4; mode++) begin
                     @(posedge clk21m);
                     hdmi_width         <= 12'(widths[wi]);
                     hdmi_height        <= 12'(heights[hi]);
                     forced_scandoubler <= (sdm == 1);
                     scanlines          <= (sdm == 2) ? 2'd2 : 2'd0;
                     vcrop_en           <= vc[0];
                     ar                 <= aspect_mode_e'(mode[1:0]);
                     expect_out = crop_ref(widths[wi], heights[hi], sdm != 0, vc[0], mode);
                     repeat (3) @(posedge clk21m);
                     @(negedge clk21m);
                     check_value(64'({crop_size, arx, ary}), 64'(expect_out),
                                 $sformatf("crop w=%0d h=%0d sd=%0d vcrop=%0d ar=%0d",
                                           widths[wi], heights[hi], sdm, vc, mode));
                  end
      end
   endtask

   // ======================================================================
   // Main sequence
   // ======================================================================

   initial begin
      clk21m = 1'b0;
      reset = 1'b1;
      tx = 1'b0;
      rx = 1'b0;
      tx_data = '0;
      card_ss = 1'b0;
      img_mounted = 1'b0;
      img_size = '0;
      sd_miso = 1'b1;
      vsd_miso = 1'b0;
      hdmi_width = '0;
      hdmi_height = '0;
      forced_scandoubler = 1'b0;
      scanlines = '0;
      vcrop_en = 1'b0;
      ar = AR_ORIGINAL;
      lfsr_state = 16'd81;
      virt_sel = 1'b0;
      have_reply = 1'b0;
      last_reply = '0;

      repeat (3) @(posedge clk21m);
      reset <= 1'b0;
      @(negedge clk21m);
      check_value(64'({ready, rx_data}), 64'h100, "ready and rx_data after reset");
      check_value(64'({led_user, led_disk}), 64'd0, "LEDs after reset");
      check_value(64'({crop_size, arx, ary}), 64'd0, "crop outputs after reset");
      check_value(64'({sd_cs, vsd_cs}), 64'b01, "physical card selected after reset");

      // Physical card: writes, then read strobes
      random_transfers(20, 1'b0);
      for (int k = 0; k < 3; k++) begin
         run_transfer(1'b1, 8'h00, 8'h3C + 8'(k));
      end
      check_leds_idle();
      run_transfer(1'b0, 8'h55, 8'hAA);
      check_leds_idle();

      // Virtual card
      mount_image(32'h0001_0000);
      check_card_ss();
      check_leds_idle();
      run_transfer(1'b0, 8'h55, 8'hAA);
      random_transfers(10, 1'b1);
      check_leds_idle();

      // Back to the physical card
      mount_image(32'd0);
      random_transfers(5, 1'b1);
      check_leds_idle();

      sweep_crop();

      if (DUT.u_checks.failures != 0) begin
         $display("Assertion failures: %0d", DUT.u_checks.failures);
         $display("Simulation failed");
         $fatal(1, "assertions failed");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

endmodule

// File: files.f
src/msx_glue_pkg.sv
src/spi_byte_engine.sv
src/sd_activity_monitor.sv
src/sd_route.sv
src/hdmi_crop_select.sv
src/msx_board_io.sv
bench/msx_board_io_assert.sv
bench/tb_msx_board_io.sv

// File: Makefile
# Verilator build for the MSX board I/O testbench

VERILATOR ?= verilator
TOP       ?= tb_msx_board_io
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
